// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     = --timing --assert
TOP       = tb_vending_machine
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)

sim: build
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== files.f ====
logic/vend_pkg.sv
logic/bank_if.sv
logic/vend_ctrl.sv
logic/coin_acceptor.sv
logic/coin_bank.sv
logic/change_dispenser.sv
logic/vending_machine.sv
verif/tb_clk_gen.sv
verif/vending_machine_asserts.sv
verif/tb_vending_machine.sv

// ==== logic/bank_if.sv ====
`timescale 1ns/1ps

interface bank_if import vend_pkg::*; ();

	// Coins taken in during collection
	logic                 deposit_valid;
	coin_t                deposit_code;

	// Coins handed out as change
	logic                 payout_valid;
	coin_t                payout_code;

	// One bit per denomination, bit 0 is coin code 1
	logic [NUM_COINS-1:0] in_stock;

	modport acceptor (output deposit_valid, output deposit_code);

	modport dispenser (output payout_valid, output payout_code, input in_stock);

	modport bank (
		input  deposit_valid,
		input  deposit_code,
		input  payout_valid,
		input  payout_code,
		output in_stock
	);

endinterface

// ==== logic/change_dispenser.sv ====
`timescale 1ns/1ps

module change_dispenser import vend_pkg::*;
(
	input  logic            i_clk,
	input  logic            i_rst_n,
	input  logic            i_load,
	input  amount_t         i_wallet,
	input  amount_t         i_price,
	output coin_t           o_change_code,
	output logic            o_change_valid,
	output logic            o_no_change,
	output logic            o_done,
	bank_if.dispenser       bank_bus
);

	amount_t remain;
	logic    active;
	logic    pick_found;
	coin_t   pick_code;
	amount_t pick_value;
	logic    owing;

	assign owing = (remain != '0);

	// ======================================================================
	// Greedy search over stocked coins
	// ======================================================================

	// Scan runs from the smallest coin up, so the largest fit wins
	always_comb
	begin
		pick_found = 1'b0;
		pick_code  = COIN_NONE;
		pick_value = '0;
		for (int i = NUM_COINS - 1; i >= 0; i--)
		begin
			if (bank_bus.in_stock[i] && (COIN_VALUE[i] <= remain))
			begin
				pick_found = 1'b1;
				pick_code  = coin_t'(i + 1);
				pick_value = COIN_VALUE[i];
			end
		end
	end

	assign bank_bus.payout_valid = owing && pick_found;
	assign bank_bus.payout_code  = pick_code;

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			remain         <= '0;
			active         <= 1'b0;
			o_change_valid <= 1'b0;
			o_no_change    <= 1'b0;
			o_change_code  <= COIN_NONE;
		end
		else
		begin
			active         <= i_load || (active && owing);
			o_change_valid <= owing;
			o_no_change    <= owing && !pick_found;
			o_change_code  <= (owing && pick_found) ? pick_code : COIN_NONE;
			if (i_load)
				remain <= i_wallet - i_price;
			else if (owing)
				// A remainder that cannot be paid is dropped after the no-change pulse
				remain <= pick_found ? (remain - pick_value) : '0;
		end
	end

	// Also high in the cycle that shows the last coin or the no-change pulse
	assign o_done = active && !owing;

endmodule

// ==== logic/coin_acceptor.sv ====
`timescale 1ns/1ps

module coin_acceptor import vend_pkg::*;
(
	input  logic            i_clk,
	input  logic            i_rst_n,
	input  coin_t           i_money,
	input  logic            i_money_valid,
	input  logic            i_collect_en,
	input  amount_t         i_price,
	input  logic            i_clear,
	output amount_t         o_wallet,
	output logic            o_paid,
	bank_if.acceptor        bank_bus
);

	logic  accept;
	coin_t coin_idx;

	assign o_paid   = (o_wallet >= i_price);
	assign coin_idx = i_money - 4'd1;

	// Coins arriving after the price is reached are refused
	assign accept = i_collect_en && i_money_valid && (i_money != COIN_NONE) && !o_paid;

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
			o_wallet <= '0;
		else if (i_clear)
			o_wallet <= '0;
		else if (accept)
			o_wallet <= o_wallet + COIN_VALUE[coin_idx];
	end

	// Same coin goes to the bank so its stock rises at this edge
	assign bank_bus.deposit_valid = accept;
	assign bank_bus.deposit_code  = i_money;

endmodule

// ==== logic/coin_bank.sv ====
`timescale 1ns/1ps

module coin_bank import vend_pkg::*;
#(
	parameter int p_init_stock = 100
)
(
	input  logic    i_clk,
	input  logic    i_rst_n,
	bank_if.bank    bank_bus
);

	stock_t stock [NUM_COINS];

	// ======================================================================
	// Stock counters, one per denomination
	// ======================================================================

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			for (int i = 0; i < NUM_COINS; i++)
				stock[i] <= stock_t'(p_init_stock);
		end
		else
		begin
			// Deposits and payouts are never in the same cycle
			for (int i = 0; i < NUM_COINS; i++)
			begin
				if (bank_bus.deposit_valid && (bank_bus.deposit_code == coin_t'(i + 1)))
					stock[i] <= stock[i] + 16'd1;
				else if (bank_bus.payout_valid && (bank_bus.payout_code == coin_t'(i + 1)))
					stock[i] <= stock[i] - 16'd1;
			end
		end
	end

	always_comb
	begin
		for (int i = 0; i < NUM_COINS; i++)
			bank_bus.in_stock[i] = (stock[i] != '0);
	end

endmodule

// ==== logic/vend_ctrl.sv ====
`timescale 1ns/1ps

module vend_ctrl import vend_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_rst_n,
	input  logic        i_buy,
	input  product_t    i_product_code,
	input  logic        i_product_ready,
	input  logic        i_paid,
	input  logic        i_change_done,
	output product_t    o_product_code,
	output amount_t     o_price,
	output logic        o_collect_en,
	output logic        o_load,
	output logic        o_clear,
	output logic        o_product_valid,
	output logic        o_busy
);

	vend_state_t state;
	vend_state_t state_nxt;
	logic        code_ok;
	logic [2:0]  price_idx;
	logic        handover;

	assign code_ok   = (i_product_code >= PROD_ESPRESSO) && (i_product_code <= PROD_SNICKERS);
	assign price_idx = 3'(i_product_code - 4'd1);

	// Product leaves the machine and the change is handed to the dispenser
	assign handover = (state == ST_DISPENSE) && i_product_ready;

	// ======================================================================
	// Next state
	// ======================================================================

	always_comb
	begin
		state_nxt = state;
		case (state)
			ST_SELECT:
				if (i_buy && code_ok)
					state_nxt = ST_COLLECT;
			ST_COLLECT:
				if (i_paid)
					state_nxt = ST_DISPENSE;
			ST_DISPENSE:
				if (i_product_ready)
					state_nxt = ST_CHANGE;
			ST_CHANGE:
				if (i_change_done)
					state_nxt = ST_SELECT;
			default:
				state_nxt = ST_SELECT;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state          <= ST_SELECT;
			o_product_code <= '0;
			o_price        <= '0;
		end
		else
		begin
			state <= state_nxt;
			// Invalid codes leave the previous selection untouched
			if ((state == ST_SELECT) && i_buy && code_ok)
			begin
				o_product_code <= i_product_code;
				o_price        <= PRODUCT_PRICE[price_idx];
			end
		end
	end

	assign o_collect_en    = (state == ST_COLLECT);
	assign o_load          = handover;
	assign o_clear         = handover;
	assign o_product_valid = (state == ST_DISPENSE);
	assign o_busy          = (state == ST_DISPENSE) || (state == ST_CHANGE);

endmodule

// ==== logic/vend_pkg.sv ====
package vend_pkg;

	// ======================================================================
	// Basic types, all money counted in hundredths
	// ======================================================================

	typedef logic [3:0]  product_t;
	typedef logic [3:0]  coin_t;
	typedef logic [19:0] amount_t;
	typedef logic [15:0] stock_t;

	localparam int NUM_COINS    = 15;
	localparam int NUM_PRODUCTS = 8;

	// Product codes, zero and anything above eight are not sold
	localparam product_t PROD_ESPRESSO  = 4'd1;
	localparam product_t PROD_AMERICANO = 4'd2;
	localparam product_t PROD_LATTE     = 4'd3;
	localparam product_t PROD_TEA       = 4'd4;
	localparam product_t PROD_MILK      = 4'd5;
	localparam product_t PROD_CHOCOLATE = 4'd6;
	localparam product_t PROD_NUTS      = 4'd7;
	localparam product_t PROD_SNICKERS  = 4'd8;

	// Code 0 on a coin bus means no coin
	localparam coin_t COIN_NONE = 4'd0;

	// Indexed by coin code minus one, largest denomination first
	localparam amount_t COIN_VALUE [NUM_COINS] = '{
		20'd50000, 20'd20000, 20'd10000, 20'd5000, 20'd2000,
		20'd1000,  20'd500,   20'd200,   20'd100,  20'd50,
		20'd25,    20'd10,    20'd5,     20'd2,    20'd1
	};

	// Indexed by product code minus one
	localparam amount_t PRODUCT_PRICE [NUM_PRODUCTS] = '{
		20'd320, 20'd350, 20'd400, 20'd420,
		20'd450, 20'd300, 20'd900, 20'd800
	};

	// ======================================================================
	// Transaction FSM
	// ======================================================================

	typedef enum logic [1:0]
	{
		ST_SELECT   = 2'd0,
		ST_COLLECT  = 2'd1,
		ST_DISPENSE = 2'd2,
		ST_CHANGE   = 2'd3
	} vend_state_t;

endpackage

// ==== logic/vending_machine.sv ====
`timescale 1ns/1ps

module vending_machine import vend_pkg::*;
#(
	parameter int p_init_stock = 100
)
(
	input  logic     i_clk,
	input  logic     i_rst_n,
	input  coin_t    i_money,
	input  logic     i_money_valid,
	input  product_t i_product_code,
	input  logic     i_buy,
	input  logic     i_product_ready,
	output product_t o_product_code,
	output logic     o_product_valid,
	output logic     o_busy,
	output coin_t    o_change_denomination_code,
	output logic     o_change_valid,
	output logic     o_no_change
);

	amount_t price;
	amount_t wallet;
	logic    collect_en;
	logic    paid;
	logic    load;
	logic    clear;
	logic    change_done;

	bank_if bank_bus ();

	// ======================================================================
	// Controller and working units
	// ======================================================================

	vend_ctrl u_ctrl (
		.i_clk           (i_clk),
		.i_rst_n         (i_rst_n),
		.i_buy           (i_buy),
		.i_product_code  (i_product_code),
		.i_product_ready (i_product_ready),
		.i_paid          (paid),
		.i_change_done   (change_done),
		.o_product_code  (o_product_code),
		.o_price         (price),
		.o_collect_en    (collect_en),
		.o_load          (load),
		.o_clear         (clear),
		.o_product_valid (o_product_valid),
		.o_busy          (o_busy)
	);

	coin_acceptor u_acceptor (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_money       (i_money),
		.i_money_valid (i_money_valid),
		.i_collect_en  (collect_en),
		.i_price       (price),
		.i_clear       (clear),
		.o_wallet      (wallet),
		.o_paid        (paid),
		.bank_bus      (bank_bus.acceptor)
	);

	coin_bank #(
		.p_init_stock (p_init_stock)
	) u_bank (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.bank_bus (bank_bus.bank)
	);

	change_dispenser u_dispenser (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_load         (load),
		.i_wallet       (wallet),
		.i_price        (price),
		.o_change_code  (o_change_denomination_code),
		.o_change_valid (o_change_valid),
		.o_no_change    (o_no_change),
		.o_done         (change_done),
		.bank_bus       (bank_bus.dispenser)
	);

endmodule

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen
(
	output logic o_clk,
	output logic o_rst_n
);

	initial
	begin
		o_clk = 1'b0;
		forever
			#2 o_clk = ~o_clk;
	end

	// Reset goes low just after time zero so the asynchronous reset sees an edge
	initial
	begin
		o_rst_n = 1'b1;
		#1;
		o_rst_n = 1'b0;
		repeat (16) @(posedge o_clk);
		o_rst_n <= 1'b1;
	end

endmodule

// ==== verif/tb_vending_machine.sv ====
`timescale 1ns/1ps

module tb_vending_machine import vend_pkg::*; ();

	localparam int STOCK_INIT = 3;
	localparam int TIMEOUT    = 200;

	logic     i_clk;
	logic     i_rst_n;
	coin_t    i_money;
	logic     i_money_valid;
	product_t i_product_code;
	logic     i_buy;
	logic     i_product_ready;
	product_t o_product_code;
	logic     o_product_valid;
	logic     o_busy;
	coin_t    o_change_denomination_code;
	logic     o_change_valid;
	logic     o_no_change;

	int          stock_model [NUM_COINS];
	logic [31:0] lfsr;
	coin_t       last_codes [$];
	logic        last_no_change;

	tb_clk_gen u_clk_gen (.o_clk(i_clk), .o_rst_n(i_rst_n));

	vending_machine #(.p_init_stock(STOCK_INIT)) dut (
		.i_clk                      (i_clk),
		.i_rst_n                    (i_rst_n),
		.i_money                    (i_money),
		.i_money_valid              (i_money_valid),
		.i_product_code             (i_product_code),
		.i_buy                      (i_buy),
		.i_product_ready            (i_product_ready),
		.o_product_code             (o_product_code),
		.o_product_valid            (o_product_valid),
		.o_busy                     (o_busy),
		.o_change_denomination_code (o_change_denomination_code),
		.o_change_valid             (o_change_valid),
		.o_no_change                (o_no_change)
	);

	// ======================================================================
	// Reference tables, error reporting and compares
	// ======================================================================

	function automatic int coin_value(input coin_t code);
		case (code)
			4'd1: return 50000;
			4'd2: return 20000;
			4'd3: return 10000;
			4'd4: return 5000;
			4'd5: return 2000;
			4'd6: return 1000;
			4'd7: return 500;
			4'd8: return 200;
			4'd9: return 100;
			4'd10: return 50;
			4'd11: return 25;
			4'd12: return 10;
			4'd13: return 5;
			4'd14: return 2;
			4'd15: return 1;
			default: return 0;
		endcase
	endfunction

	function automatic int product_price(input product_t code);
		case (code)
			4'd1: return 320;
			4'd2: return 350;
			4'd3: return 400;
			4'd4: return 420;
			4'd5: return 450;
			4'd6: return 300;
			4'd7: return 900;
			4'd8: return 800;
			default: return 0;
		endcase
	endfunction

	task automatic fail_value(input string msg);
		$display("ERR @ %0t ns: %s", $time, msg);
		$display("Test failures found");
		$fatal(1, "stopped at first error");
	endtask

	task automatic fail_plain(input string msg);
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_product(input product_t got, input product_t exp, input string what);
		if (got !== exp)
			fail_value($sformatf("%s: got %0d, expected %0d", what, got, exp));
	endtask

	task automatic check_coin(input coin_t got, input coin_t exp, input string what);
		if (got !== exp)
			fail_value($sformatf("%s: got %0d, expected %0d", what, got, exp));
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
			fail_value($sformatf("%s: got %b, expected %b", what, got, exp));
	endtask

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'hA300_0000;
		else
			return s >> 1;
	endfunction

	task automatic get_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
	endtask

	// Greedy payout from the modelled stock, a code of zero marks no change
	task automatic model_change(input int change, output coin_t codes [$], output int left);
		int   idx;
		codes = {};
		left  = change;
		while (left > 0)
		begin
			idx = -1;
			for (int i = 0; i < NUM_COINS && idx < 0; i++)
				if (stock_model[i] > 0 && coin_value(coin_t'(i + 1)) <= left)
					idx = i;
			if (idx < 0)
			begin
				codes.push_back(COIN_NONE);
				break;
			end
			codes.push_back(coin_t'(idx + 1));
			stock_model[idx]--;
			left -= coin_value(coin_t'(idx + 1));
		end
	endtask

	// ======================================================================
	// Drivers and waits
	// ======================================================================

	task automatic select_product(input product_t code);
		@(posedge i_clk);
		i_buy          <= 1'b1;
		i_product_code <= code;
		@(posedge i_clk);
		i_buy          <= 1'b0;
	endtask

	task automatic insert_coins(input coin_t coins [$]);
		foreach (coins[i])
		begin
			@(posedge i_clk);
			i_money       <= coins[i];
			i_money_valid <= 1'b1;
		end
		@(posedge i_clk);
		i_money       <= COIN_NONE;
		i_money_valid <= 1'b0;
	endtask

	task automatic wait_product_valid();
		int n;
		n = 0;
		@(negedge i_clk);
		while (o_product_valid !== 1'b1)
		begin
			if (n == TIMEOUT)
				fail_plain("Timed out waiting for the product to be offered");
			else
			begin
				@(negedge i_clk);
				n++;
			end
		end
	endtask

	task automatic purchase(input product_t prod, input coin_t coins [$], input int delay);
		int    wallet;
		int    price;
		int    left;
		int    paid_back;
		int    n;
		int    idx;
		bit    done;
		logic  seen_nc;
		coin_t exp_codes [$];
		price  = product_price(prod);
		wallet = 0;
		foreach (coins[i])
		begin
			if (wallet < price)
			begin
				wallet += coin_value(coins[i]);
				idx = int'(coins[i]) - 1;
				stock_model[idx]++;
			end
		end
		model_change(wallet - price, exp_codes, left);

		select_product(prod);
		insert_coins(coins);
		wait_product_valid();
		check_product(o_product_code, prod, "selected product");
		check_flag(o_busy, 1'b1, "busy while offering product");
		repeat (delay)
		begin
			@(negedge i_clk);
			check_flag(o_product_valid, 1'b1, "product held until ready");
		end
		@(posedge i_clk);
		i_product_ready <= 1'b1;
		@(posedge i_clk);
		i_product_ready <= 1'b0;

		last_codes = {};
		seen_nc    = 1'b0;
		paid_back  = 0;
		done       = 1'b0;
		n          = 0;
		while (!done)
		begin
			@(negedge i_clk);
			if (o_change_valid)
			begin
				last_codes.push_back(o_change_denomination_code);
				if (o_no_change)
					seen_nc = 1'b1;
				else
					paid_back += coin_value(o_change_denomination_code);
			end
			if (!o_busy)
				done = 1'b1;
			else if (n == TIMEOUT)
				fail_plain("Timed out waiting for the change payout to finish");
			else
				n++;
		end

		if (last_codes.size() != exp_codes.size())
			fail_value($sformatf("change pulses: got %0d, expected %0d",
				last_codes.size(), exp_codes.size()));
		foreach (exp_codes[i])
			check_coin(last_codes[i], exp_codes[i], $sformatf("change coin %0d", i));
		check_flag(seen_nc, (left > 0), "no-change flag");
		if (paid_back + left != wallet - price)
			fail_value($sformatf("returned %0d plus unpaid %0d, expected %0d",
				paid_back, left, wallet - price));
		last_no_change = seen_nc;
	endtask

	// ======================================================================
	// Directed tests
	// ======================================================================

	task automatic test_reset_and_invalid();
		int n;
		n = 0;
		@(negedge i_clk);
		while (i_rst_n !== 1'b1)
		begin
			if (n == TIMEOUT)
				fail_plain("Reset was never released");
			else
			begin
				@(negedge i_clk);
				n++;
			end
		end
		@(negedge i_clk);
		check_product(o_product_code, 4'd0, "product code after reset");
		check_flag(o_product_valid, 1'b0, "product valid after reset");
		check_flag(o_busy, 1'b0, "busy after reset");
		check_coin(o_change_denomination_code, COIN_NONE, "change code after reset");
		check_flag(o_change_valid, 1'b0, "change valid after reset");
		check_flag(o_no_change, 1'b0, "no change after reset");
		select_product(4'd0);
		select_product(4'd12);
		repeat (20)
		begin
			@(negedge i_clk);
			check_flag(o_busy, 1'b0, "busy after invalid code");
			check_flag(o_product_valid, 1'b0, "product after invalid code");
		end
	endtask

	task automatic test_exact_payment();
		purchase(PROD_ESPRESSO, '{4'd8, 4'd9, 4'd12, 4'd12}, 5);
		if (last_codes.size() != 0)
			fail_value("exact payment returned change");
	endtask

	task automatic test_greedy_change();
		purchase(PROD_TEA, '{4'd7}, 0);
		if (last_codes.size() != 3)
			fail_value($sformatf("tea change pulses: got %0d, expected 3", last_codes.size()));
		check_coin(last_codes[0], 4'd10, "tea change coin 0");
		check_coin(last_codes[1], 4'd11, "tea change coin 1");
		check_coin(last_codes[2], 4'd13, "tea change coin 2");
	endtask

	task automatic test_stock_drain();
		logic nc_seen;
		nc_seen = 1'b0;
		for (int k = 0; k < 12 && !nc_seen; k++)
		begin
			purchase(PROD_MILK, '{4'd7}, 0);
			nc_seen = last_no_change;
		end
		if (!nc_seen)
			fail_plain("Stock never ran out of fitting coins during the drain test");
	endtask

	task automatic test_random_purchases();
		logic [31:0] v;
		product_t    prod;
		coin_t       coins [$];
		coin_t       c;
		int          wallet;
		for (int k = 0; k < 20; k++)
		begin
			get_bits(3, v);
			prod   = product_t'({1'b0, v[2:0]} + 4'd1);
			coins  = {};
			wallet = 0;
			while (wallet < product_price(prod))
			begin
				get_bits(3, v);
				c = coin_t'({1'b0, v[2:0]} + 4'd5);
				coins.push_back(c);
				wallet += coin_value(c);
			end
			get_bits(2, v);
			purchase(prod, coins, int'(v[1:0]));
		end
	endtask

	initial
	begin
		i_money         = COIN_NONE;
		i_money_valid   = 1'b0;
		i_product_code  = '0;
		i_buy           = 1'b0;
		i_product_ready = 1'b0;
		lfsr            = 32'h5aa8_394c;
		last_no_change  = 1'b0;
		for (int i = 0; i < NUM_COINS; i++)
			stock_model[i] = STOCK_INIT;

		test_reset_and_invalid();
		test_exact_payment();
		test_greedy_change();
		test_stock_drain();
		test_random_purchases();

		$display("All tests passed!");
		$finish;
	end

endmodule

// ==== verif/vending_machine_asserts.sv ====
`timescale 1ns/1ps

module vending_machine_asserts import vend_pkg::*;
(
	input logic     i_clk,
	input logic     i_rst_n,
	input product_t o_product_code,
	input logic     o_product_valid,
	input logic     o_busy,
	input coin_t    o_change_denomination_code,
	input logic     o_change_valid,
	input logic     o_no_change
);

	change_needs_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_change_valid |-> o_busy)
		else $error("change pulse outside a busy transaction");

	no_change_is_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_no_change |-> o_change_valid)
		else $error("no-change flag without a change pulse");

	product_or_change: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(o_product_valid && o_change_valid))
		else $error("product and change offered in the same cycle");

	// Every output sits at zero for as long as reset is held
	quiet_in_reset: assert property (@(posedge i_clk)
		!i_rst_n |-> (o_product_code == '0) && !o_product_valid && !o_busy &&
			(o_change_denomination_code == '0) && !o_change_valid && !o_no_change)
		else $error("output active during reset");

endmodule

bind vending_machine vending_machine_asserts u_asserts (
	.i_clk                      (i_clk),
	.i_rst_n                    (i_rst_n),
	.o_product_code             (o_product_code),
	.o_product_valid            (o_product_valid),
	.o_busy                     (o_busy),
	.o_change_denomination_code (o_change_denomination_code),
	.o_change_valid             (o_change_valid),
	.o_no_change                (o_no_change)
);
